//--- hw/procPkg.sv
package procPkg;

	//------------------------------
	// Bus widths and block map
	//------------------------------
	localparam int lpUsiBusWidth     = 32;
	localparam int lpBusAdrsBit      = 32;
	localparam int lpBlockAdrsMap    = 4;
	localparam int lpCsrAdrsWidth    = 16;
	localparam int lpBusBlockConnect = 2;

	localparam logic [lpBlockAdrsMap-1:0] lpGpioAdrsMap = 4'h1;
	localparam logic [lpBlockAdrsMap-1:0] lpVtbAdrsMap  = 4'h4;

	//------------------------------
	// CSR offsets
	//------------------------------
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioLedCsr      = 16'd0;
	// Bit 0 timing enable, bit 1 backlight
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbCtrlCsr      = 16'd0;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbHdisplayCsr  = 16'd1;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbHfrontCsr    = 16'd2;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbHbackCsr     = 16'd3;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbHpulseCsr    = 16'd4;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbVdisplayCsr  = 16'd5;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbVfrontCsr    = 16'd6;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbVbackCsr     = 16'd7;
	localparam logic [lpCsrAdrsWidth-1:0] lpVtbVpulseCsr    = 16'd8;

	// Bits 1:0 led, then B, G, R
	localparam int lpGpioLedWidth = 5;
	localparam int lpVtbCtrlWidth = 2;

	//------------------------------
	// TFT timing fields
	//------------------------------
	localparam int lpHdisplayWidth = 11;
	localparam int lpHfrontWidth   = 7;
	localparam int lpHbackWidth    = 7;
	localparam int lpHpulseWidth   = 7;
	localparam int lpVdisplayWidth = 11;
	localparam int lpVfrontWidth   = 5;
	localparam int lpVbackWidth    = 5;
	localparam int lpVpulseWidth   = 5;
	// Wide enough for the largest total of four fields
	localparam int lpSyncCntWidth  = 12;

	localparam logic [lpHdisplayWidth-1:0] lpHdisplay = 11'd480;
	localparam logic [lpHfrontWidth-1:0]   lpHfront   = 7'd8;
	localparam logic [lpHbackWidth-1:0]    lpHback    = 7'd43;
	localparam logic [lpHpulseWidth-1:0]   lpHpulse   = 7'd30;
	localparam logic [lpVdisplayWidth-1:0] lpVdisplay = 11'd272;
	localparam logic [lpVfrontWidth-1:0]   lpVfront   = 5'd12;
	localparam logic [lpVbackWidth-1:0]    lpVback    = 5'd4;
	localparam logic [lpVpulseWidth-1:0]   lpVpulse   = 5'd10;

	// Address word, raw on the bus and split into fields at the slaves
	typedef union packed {
		logic [lpBusAdrsBit-1:0] raw;
		struct packed {
			logic [lpBusAdrsBit-lpBlockAdrsMap-lpCsrAdrsWidth-1:0] rsvd;
			logic [lpBlockAdrsMap-1:0] block;
			logic [lpCsrAdrsWidth-1:0] csr;
		} field;
	} usiAdrsT;

endpackage

//--- hw/usiBus.sv
`timescale 1ns/1ps

module usiBus (
	input  logic                              sysClk,
	input  logic                              rstN,
	// Master request
	input  logic [procPkg::lpUsiBusWidth-1:0] usiWd,
	input  logic [procPkg::lpBusAdrsBit-1:0]  usiAdrs,
	input  logic                              usiWEd,
	input  logic                              usiREd,
	// Slave responses
	input  logic [procPkg::lpUsiBusWidth-1:0] slvRdGpio,
	input  logic                              slvRValidGpio,
	input  logic [procPkg::lpUsiBusWidth-1:0] slvRdVtb,
	input  logic                              slvRValidVtb,
	// Broadcast to every slave
	output logic [procPkg::lpUsiBusWidth-1:0] slvWd,
	output procPkg::usiAdrsT                  slvAdrs,
	output logic                              slvWEd,
	output logic                              slvREd,
	// Merged read channel
	output logic [procPkg::lpUsiBusWidth-1:0] usiRd,
	output logic                              usiRValid
);

	logic [procPkg::lpBusBlockConnect-1:0][procPkg::lpUsiBusWidth-1:0] slvRdVec;
	logic [procPkg::lpBusBlockConnect-1:0]                            slvRValidVec;

	//------------------------------
	// Request register
	//------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			slvWEd <= 1'b0;
			slvREd <= 1'b0;
		end
		else
		begin
			slvWEd <= usiWEd;
			slvREd <= usiREd;
		end
	end

	// Data and address follow the strobes
	always_ff @(posedge sysClk)
	begin
		slvWd       <= usiWd;
		slvAdrs.raw <= usiAdrs;
	end

	//------------------------------
	// Read merge
	//------------------------------
	// Idle slaves drive zero, so a plain OR is enough
	assign slvRdVec     = {slvRdVtb, slvRdGpio};
	assign slvRValidVec = {slvRValidVtb, slvRValidGpio};

	always_comb
	begin
		usiRd = '0;
		for (int i = 0; i < procPkg::lpBusBlockConnect; i++)
		begin
			usiRd = usiRd | slvRdVec[i];
		end
	end

	assign usiRValid = |slvRValidVec;

endmodule

//--- hw/gpioBlock.sv
`timescale 1ns/1ps

module gpioBlock (
	input  logic                              sysClk,
	input  logic                              rstN,
	input  logic [procPkg::lpUsiBusWidth-1:0] slvWd,
	input  procPkg::usiAdrsT                  slvAdrs,
	input  logic                              slvWEd,
	input  logic                              slvREd,
	output logic [procPkg::lpUsiBusWidth-1:0] slvRd,
	output logic                              slvRValid,
	output logic [1:0]                        led,
	output logic                              ledB,
	output logic                              ledG,
	output logic                              ledR
);

	logic [procPkg::lpGpioLedWidth-1:0] ledReg;
	logic [procPkg::lpUsiBusWidth-1:0]  rdData;
	logic                               csrHit;

	// Only one CSR lives in this block
	assign csrHit = (slvAdrs.field.block == procPkg::lpGpioAdrsMap)
		&& (slvAdrs.field.csr == procPkg::lpGpioLedCsr);

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			ledReg <= '0;
		else if (slvWEd && csrHit)
			ledReg <= slvWd[procPkg::lpGpioLedWidth-1:0];
	end

	//------------------------------
	// Readback
	//------------------------------
	always_comb
	begin
		rdData = '0;
		rdData[procPkg::lpGpioLedWidth-1:0] = ledReg;
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			slvRValid <= 1'b0;
		else
			slvRValid <= slvREd && csrHit;
	end

	// Zero when idle keeps the bus OR clean
	always_ff @(posedge sysClk)
		slvRd <= (slvREd && csrHit) ? rdData : '0;

	assign led  = ledReg[1:0];
	assign ledB = ledReg[2];
	assign ledG = ledReg[3];
	assign ledR = ledReg[4];

endmodule

//--- hw/videoSyncGen.sv
`timescale 1ns/1ps

module videoSyncGen (
	input  logic                                sysClk,
	input  logic                                rstN,
	input  logic                                enable,
	input  logic [procPkg::lpHdisplayWidth-1:0] hDisplay,
	input  logic [procPkg::lpHfrontWidth-1:0]   hFront,
	input  logic [procPkg::lpHbackWidth-1:0]    hBack,
	input  logic [procPkg::lpHpulseWidth-1:0]   hPulse,
	input  logic [procPkg::lpVdisplayWidth-1:0] vDisplay,
	input  logic [procPkg::lpVfrontWidth-1:0]   vFront,
	input  logic [procPkg::lpVbackWidth-1:0]    vBack,
	input  logic [procPkg::lpVpulseWidth-1:0]   vPulse,
	output logic                                hSync,
	output logic                                vSync,
	output logic                                de
);

	logic [procPkg::lpSyncCntWidth-1:0] hCnt, vCnt;
	logic [procPkg::lpSyncCntWidth-1:0] hStart, hEnd, hTotal;
	logic [procPkg::lpSyncCntWidth-1:0] vStart, vEnd, vTotal;

	// Line layout is pulse, back porch, display, front porch
	assign hStart = procPkg::lpSyncCntWidth'(hPulse) + procPkg::lpSyncCntWidth'(hBack);
	assign hEnd   = hStart + procPkg::lpSyncCntWidth'(hDisplay);
	assign hTotal = hEnd + procPkg::lpSyncCntWidth'(hFront);
	assign vStart = procPkg::lpSyncCntWidth'(vPulse) + procPkg::lpSyncCntWidth'(vBack);
	assign vEnd   = vStart + procPkg::lpSyncCntWidth'(vDisplay);
	assign vTotal = vEnd + procPkg::lpSyncCntWidth'(vFront);

	//------------------------------
	// Counters
	//------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN || !enable)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hCnt == hTotal - 1'b1)
		begin
			hCnt <= '0;
			vCnt <= (vCnt == vTotal - 1'b1) ? '0 : vCnt + 1'b1;
		end
		else
			hCnt <= hCnt + 1'b1;
	end

	//------------------------------
	// Registered outputs
	//------------------------------
	// Syncs are active low and idle high
	always_ff @(posedge sysClk)
	begin
		if (!rstN || !enable)
		begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			de    <= 1'b0;
		end
		else
		begin
			hSync <= (hCnt >= procPkg::lpSyncCntWidth'(hPulse));
			vSync <= (vCnt >= procPkg::lpSyncCntWidth'(vPulse));
			de    <= (hCnt >= hStart) && (hCnt < hEnd) && (vCnt >= vStart) && (vCnt < vEnd);
		end
	end

endmodule

//--- hw/videoTxBlock.sv
`timescale 1ns/1ps

module videoTxBlock (
	input  logic                              sysClk,
	input  logic                              rstN,
	input  logic [procPkg::lpUsiBusWidth-1:0] slvWd,
	input  procPkg::usiAdrsT                  slvAdrs,
	input  logic                              slvWEd,
	input  logic                              slvREd,
	output logic [procPkg::lpUsiBusWidth-1:0] slvRd,
	output logic                              slvRValid,
	output logic                              tftHSync,
	output logic                              tftVSync,
	output logic                              tftDe,
	output logic                              tftBackLight
);

	logic [procPkg::lpVtbCtrlWidth-1:0]  ctrlReg;
	logic [procPkg::lpHdisplayWidth-1:0] hDisplay;
	logic [procPkg::lpHfrontWidth-1:0]   hFront;
	logic [procPkg::lpHbackWidth-1:0]    hBack;
	logic [procPkg::lpHpulseWidth-1:0]   hPulse;
	logic [procPkg::lpVdisplayWidth-1:0] vDisplay;
	logic [procPkg::lpVfrontWidth-1:0]   vFront;
	logic [procPkg::lpVbackWidth-1:0]    vBack;
	logic [procPkg::lpVpulseWidth-1:0]   vPulse;
	logic [procPkg::lpUsiBusWidth-1:0]   rdData;
	logic                                rdHit;
	logic                                blockHit;

	assign blockHit = (slvAdrs.field.block == procPkg::lpVtbAdrsMap);

	//------------------------------
	// CSR bank
	//------------------------------
	// Each write keeps only the low bits of its field
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ctrlReg  <= '0;
			hDisplay <= procPkg::lpHdisplay;
			hFront   <= procPkg::lpHfront;
			hBack    <= procPkg::lpHback;
			hPulse   <= procPkg::lpHpulse;
			vDisplay <= procPkg::lpVdisplay;
			vFront   <= procPkg::lpVfront;
			vBack    <= procPkg::lpVback;
			vPulse   <= procPkg::lpVpulse;
		end
		else if (slvWEd && blockHit)
		begin
			case (slvAdrs.field.csr)
				procPkg::lpVtbCtrlCsr:     ctrlReg  <= slvWd[procPkg::lpVtbCtrlWidth-1:0];
				procPkg::lpVtbHdisplayCsr: hDisplay <= slvWd[procPkg::lpHdisplayWidth-1:0];
				procPkg::lpVtbHfrontCsr:   hFront   <= slvWd[procPkg::lpHfrontWidth-1:0];
				procPkg::lpVtbHbackCsr:    hBack    <= slvWd[procPkg::lpHbackWidth-1:0];
				procPkg::lpVtbHpulseCsr:   hPulse   <= slvWd[procPkg::lpHpulseWidth-1:0];
				procPkg::lpVtbVdisplayCsr: vDisplay <= slvWd[procPkg::lpVdisplayWidth-1:0];
				procPkg::lpVtbVfrontCsr:   vFront   <= slvWd[procPkg::lpVfrontWidth-1:0];
				procPkg::lpVtbVbackCsr:    vBack    <= slvWd[procPkg::lpVbackWidth-1:0];
				procPkg::lpVtbVpulseCsr:   vPulse   <= slvWd[procPkg::lpVpulseWidth-1:0];
				default: ;
			endcase
		end
	end

	//------------------------------
	// Readback
	//------------------------------
	always_comb
	begin
		rdData = '0;
		rdHit  = 1'b1;
		case (slvAdrs.field.csr)
			procPkg::lpVtbCtrlCsr:     rdData[procPkg::lpVtbCtrlWidth-1:0]  = ctrlReg;
			procPkg::lpVtbHdisplayCsr: rdData[procPkg::lpHdisplayWidth-1:0] = hDisplay;
			procPkg::lpVtbHfrontCsr:   rdData[procPkg::lpHfrontWidth-1:0]   = hFront;
			procPkg::lpVtbHbackCsr:    rdData[procPkg::lpHbackWidth-1:0]    = hBack;
			procPkg::lpVtbHpulseCsr:   rdData[procPkg::lpHpulseWidth-1:0]   = hPulse;
			procPkg::lpVtbVdisplayCsr: rdData[procPkg::lpVdisplayWidth-1:0] = vDisplay;
			procPkg::lpVtbVfrontCsr:   rdData[procPkg::lpVfrontWidth-1:0]   = vFront;
			procPkg::lpVtbVbackCsr:    rdData[procPkg::lpVbackWidth-1:0]    = vBack;
			procPkg::lpVtbVpulseCsr:   rdData[procPkg::lpVpulseWidth-1:0]   = vPulse;
			default:                   rdHit = 1'b0;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			slvRValid <= 1'b0;
		else
			slvRValid <= slvREd && blockHit && rdHit;
	end

	always_ff @(posedge sysClk)
		slvRd <= (slvREd && blockHit && rdHit) ? rdData : '0;

	assign tftBackLight = ctrlReg[1];

	//------------------------------
	// Sync generator
	//------------------------------
	videoSyncGen uVideoSyncGen (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.enable   (ctrlReg[0]),
		.hDisplay (hDisplay),
		.hFront   (hFront),
		.hBack    (hBack),
		.hPulse   (hPulse),
		.vDisplay (vDisplay),
		.vFront   (vFront),
		.vBack    (vBack),
		.vPulse   (vPulse),
		.hSync    (tftHSync),
		.vSync    (tftVSync),
		.de       (tftDe)
	);

endmodule

//--- hw/processor.sv
`timescale 1ns/1ps

module processor (
	input  logic                              sysClk,
	input  logic                              rstN,
	input  logic [procPkg::lpUsiBusWidth-1:0] usiWd,
	input  logic [procPkg::lpBusAdrsBit-1:0]  usiAdrs,
	input  logic                              usiWEd,
	input  logic                              usiREd,
	output logic [procPkg::lpUsiBusWidth-1:0] usiRd,
	output logic                              usiRValid,
	output logic [1:0]                        led,
	output logic                              ledB,
	output logic                              ledG,
	output logic                              ledR,
	output logic                              tftHSync,
	output logic                              tftVSync,
	output logic                              tftDe,
	output logic                              tftBackLight
);

	// Broadcast side of the bus
	logic [procPkg::lpUsiBusWidth-1:0] slvWd;
	procPkg::usiAdrsT                  slvAdrs;
	logic                              slvWEd;
	logic                              slvREd;
	// Slave responses
	logic [procPkg::lpUsiBusWidth-1:0] slvRdGpio;
	logic                              slvRValidGpio;
	logic [procPkg::lpUsiBusWidth-1:0] slvRdVtb;
	logic                              slvRValidVtb;

	//------------------------------
	// USI bus
	//------------------------------
	usiBus uUsiBus (
		.sysClk        (sysClk),
		.rstN          (rstN),
		.usiWd         (usiWd),
		.usiAdrs       (usiAdrs),
		.usiWEd        (usiWEd),
		.usiREd        (usiREd),
		.slvRdGpio     (slvRdGpio),
		.slvRValidGpio (slvRValidGpio),
		.slvRdVtb      (slvRdVtb),
		.slvRValidVtb  (slvRValidVtb),
		.slvWd         (slvWd),
		.slvAdrs       (slvAdrs),
		.slvWEd        (slvWEd),
		.slvREd        (slvREd),
		.usiRd         (usiRd),
		.usiRValid     (usiRValid)
	);

	//------------------------------
	// Slaves
	//------------------------------
	gpioBlock uGpioBlock (
		.sysClk    (sysClk),
		.rstN      (rstN),
		.slvWd     (slvWd),
		.slvAdrs   (slvAdrs),
		.slvWEd    (slvWEd),
		.slvREd    (slvREd),
		.slvRd     (slvRdGpio),
		.slvRValid (slvRValidGpio),
		.led       (led),
		.ledB      (ledB),
		.ledG      (ledG),
		.ledR      (ledR)
	);

	videoTxBlock uVideoTxBlock (
		.sysClk       (sysClk),
		.rstN         (rstN),
		.slvWd        (slvWd),
		.slvAdrs      (slvAdrs),
		.slvWEd       (slvWEd),
		.slvREd       (slvREd),
		.slvRd        (slvRdVtb),
		.slvRValid    (slvRValidVtb),
		.tftHSync     (tftHSync),
		.tftVSync     (tftVSync),
		.tftDe        (tftDe),
		.tftBackLight (tftBackLight)
	);

endmodule

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int pPeriod = 20
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	// Free running, half a period per phase
	always
		#(pPeriod / 2) clk = ~clk;

endmodule

//--- tb/tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
	input logic        sysClk,
	input logic        usiREd,
	input logic [31:0] usiRd,
	input logic        usiRValid,
	input logic [1:0]  led,
	input logic        ledB,
	input logic        ledG,
	input logic        ledR,
	input logic        tftHSync,
	input logic        tftVSync,
	input logic        tftDe,
	input logic        tftBackLight
);

	int passCount   = 0;
	int failCount   = 0;
	int cycle       = 0;
	int edgeTimeout = 400;

	// Reads announced by the stimulus in issue order
	string       expName[$];
	bit          expValid[$];
	logic [31:0] expData[$];
	// Reads on the bus waiting for their response slot
	string       dueName[$];
	logic [31:0] dueData[$];
	int          dueCycle[$];
	string       quietName[$];
	int          quietEnd[$];

	function automatic void passTest(input string name);
		passCount++;
		$display("ok %s", name);
	endfunction

	function automatic void mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		failCount++;
		$display("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act);
	endfunction

	function automatic void failTest(input string text);
		failCount++;
		$display("error: %s", text);
	endfunction

	function automatic void compareValue(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp === act)
			passTest(name);
		else
			mismatch(name, exp, act);
	endfunction

	function automatic void expectRead(input string name, input bit respond,
		input logic [31:0] data);
		expName.push_back(name);
		expValid.push_back(respond);
		expData.push_back(data);
	endfunction

	function automatic int outstanding();
		return expName.size() + dueCycle.size() + quietEnd.size();
	endfunction

	function automatic void printCounts();
		$display("tests passed %0d failed %0d", passCount, failCount);
	endfunction

	//------------------------------
	// Read channel
	//------------------------------
	// Response is due two cycles after the strobe
	always @(posedge sysClk)
	begin
		cycle++;
		if (dueCycle.size() > 0 && dueCycle[0] == cycle)
		begin
			if (usiRValid)
				compareValue(dueName[0], dueData[0], usiRd);
			else
				failTest($sformatf("%s got no usiRValid two cycles after the read", dueName[0]));
			void'(dueName.pop_front());
			void'(dueData.pop_front());
			void'(dueCycle.pop_front());
		end
		else if (usiRValid)
		begin
			if (quietName.size() > 0)
			begin
				failTest($sformatf("%s returned usiRValid", quietName[0]));
				void'(quietName.pop_front());
				void'(quietEnd.pop_front());
			end
			else
				failTest("usiRValid without a read in flight");
		end
		if (quietEnd.size() > 0 && quietEnd[0] == cycle)
		begin
			passTest(quietName[0]);
			void'(quietName.pop_front());
			void'(quietEnd.pop_front());
		end
		if (usiREd)
		begin
			if (expName.size() == 0)
				failTest("read strobe that the stimulus never announced");
			else
			begin
				if (expValid[0])
				begin
					dueName.push_back(expName[0]);
					dueData.push_back(expData[0]);
					dueCycle.push_back(cycle + 2);
				end
				else
				begin
					quietName.push_back(expName[0]);
					quietEnd.push_back(cycle + 8);
				end
				void'(expName.pop_front());
				void'(expValid.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	//------------------------------
	// Pin checks
	//------------------------------
	task automatic checkResetState(input string name);
		@(negedge sysClk);
		// RValid, LEDs, de, backlight low and both syncs idle high
		compareValue(name, 32'h3, {22'd0, usiRValid, ledR, ledG, ledB, led, tftDe,
			tftBackLight, tftHSync, tftVSync});
	endtask

	task automatic checkLeds(input string name, input logic [4:0] exp);
		@(negedge sysClk);
		compareValue(name, {27'd0, exp}, {27'd0, ledR, ledG, ledB, led});
	endtask

	task automatic checkBackLight(input string name, input logic exp);
		@(negedge sysClk);
		compareValue(name, {31'd0, exp}, {31'd0, tftBackLight});
	endtask

	//------------------------------
	// Sync measurement
	//------------------------------
	// 0 hSync, 1 vSync, else de
	function automatic logic pick(input int which);
		case (which)
			0:       return tftHSync;
			1:       return tftVSync;
			default: return tftDe;
		endcase
	endfunction

	// Cycles until the pin next moves to level or -1 on timeout
	task automatic waitEdge(input int which, input logic level, output int k);
		logic prev;
		logic cur;
		prev = pick(which);
		k    = 0;
		while (k >= 0)
		begin
			@(posedge sysClk);
			k++;
			cur = pick(which);
			if (cur == level && prev != level)
				break;
			prev = cur;
			if (k >= edgeTimeout)
				k = -1;
		end
	endtask

	// Length of the run that started on the current sample
	task automatic countRun(input int which, input logic level, output int n);
		n = 1;
		while (n > 0)
		begin
			@(posedge sysClk);
			if (pick(which) != level)
				break;
			n++;
			if (n >= edgeTimeout)
				n = -1;
		end
	endtask

	task automatic measureSync(input int expW, input int expPer, input int expRun,
		input int expLines);
		int   k;
		int   w;
		int   run;
		int   lines;
		logic prevDe;
		logic prevV;
		waitEdge(0, 1'b0, k);
		if (k < 0)
		begin
			failTest("hSync never fell after the timing was enabled");
			return;
		end
		countRun(0, 1'b0, w);
		waitEdge(0, 1'b0, k);
		if (w < 0 || k < 0)
			failTest("timeout while measuring the hSync pulse and period");
		else
		begin
			compareValue("sync hSync width", expW, w);
			compareValue("sync line period", expPer, w + k);
		end
		waitEdge(2, 1'b1, k);
		if (k < 0)
			failTest("de never rose");
		else
		begin
			countRun(2, 1'b1, run);
			if (run < 0)
				failTest("de stayed high without end");
			else
				compareValue("sync de run", expRun, run);
		end
		waitEdge(1, 1'b0, k);
		if (k < 0)
		begin
			failTest("vSync never fell");
			return;
		end
		// Count de lines up to the next vSync fall
		lines  = 0;
		k      = 0;
		prevDe = tftDe;
		prevV  = tftVSync;
		while (k >= 0)
		begin
			@(posedge sysClk);
			k++;
			if (tftDe && !prevDe)
				lines++;
			if (!tftVSync && prevV)
				break;
			prevDe = tftDe;
			prevV  = tftVSync;
			if (k >= edgeTimeout)
				k = -1;
		end
		if (k < 0)
			failTest("no second vSync fall within the frame timeout");
		else
			compareValue("sync de lines", expLines, lines);
	endtask

endmodule

//--- include/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// One Galois step, 8-bit register with taps 8,6,5,4
function automatic logic [7:0] lfsrStep(input logic [7:0] state);
	return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
endfunction

// Takes nBits bits, one step per bit, seed 84 on the first call
function automatic logic [31:0] lfsrTake(inout logic [7:0] state, input int nBits);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < nBits; i++)
	begin
		state = lfsrStep(state);
		val   = {val[30:0], state[0]};
	end
	return val;
endfunction

// Expected readback for a write of wd at a block and offset
function automatic logic [31:0] refCsr(input int block, input int offset, input logic [31:0] wd);
	int w;
	w = 0;
	if (block == procPkg::lpGpioAdrsMap && offset == 0)
		w = procPkg::lpGpioLedWidth;
	else if (block == procPkg::lpVtbAdrsMap)
	begin
		case (offset)
			0:       w = procPkg::lpVtbCtrlWidth;
			1, 5:    w = procPkg::lpHdisplayWidth;
			2, 3, 4: w = procPkg::lpHfrontWidth;
			6, 7, 8: w = procPkg::lpVfrontWidth;
			default: w = 0;
		endcase
	end
	return wd & ((32'd1 << w) - 32'd1);
endfunction

// Expected measurements at the TFT pins
function automatic void refTiming(input int hd, input int hf, input int hb, input int hp,
	input int vd, output int hSyncW, output int linePeriod, output int deRun,
	output int deLines);
	hSyncW     = hp;
	linePeriod = hp + hb + hd + hf;
	deRun      = hd;
	deLines    = vd;
endfunction

`endif

//--- tb/tbTop.sv
`timescale 1ns/1ps

module tbTop;

	`include "tbModel.svh"

	logic        sysClk;
	logic        rstN;
	logic [31:0] usiWd;
	logic [31:0] usiAdrs;
	logic        usiWEd;
	logic        usiREd;
	logic [31:0] usiRd;
	logic        usiRValid;
	logic [1:0]  led;
	logic        ledB;
	logic        ledG;
	logic        ledR;
	logic        tftHSync;
	logic        tftVSync;
	logic        tftDe;
	logic        tftBackLight;

	logic [7:0]  lfsrState;
	logic [31:0] wd;
	logic [31:0] ledExp;
	logic [31:0] vtbWd [1:8];
	// Hdisplay, Hfront, Hback, Hpulse, Vdisplay, Vfront, Vback, Vpulse
	int          syncVal [1:8];
	int          hSyncW;
	int          linePeriod;
	int          deRun;
	int          deLines;

	tbClock #(.pPeriod(20)) uClock (.clk(sysClk));

	processor u_dut (
		.sysClk       (sysClk),
		.rstN         (rstN),
		.usiWd        (usiWd),
		.usiAdrs      (usiAdrs),
		.usiWEd       (usiWEd),
		.usiREd       (usiREd),
		.usiRd        (usiRd),
		.usiRValid    (usiRValid),
		.led          (led),
		.ledB         (ledB),
		.ledG         (ledG),
		.ledR         (ledR),
		.tftHSync     (tftHSync),
		.tftVSync     (tftVSync),
		.tftDe        (tftDe),
		.tftBackLight (tftBackLight)
	);

	tbChecker uChecker (
		.sysClk       (sysClk),
		.usiREd       (usiREd),
		.usiRd        (usiRd),
		.usiRValid    (usiRValid),
		.led          (led),
		.ledB         (ledB),
		.ledG         (ledG),
		.ledR         (ledR),
		.tftHSync     (tftHSync),
		.tftVSync     (tftVSync),
		.tftDe        (tftDe),
		.tftBackLight (tftBackLight)
	);

	//------------------------------
	// Bus stimulus
	//------------------------------
	function automatic logic [31:0] makeAdrs(input int block, input int offset);
		return {12'd0, block[3:0], offset[15:0]};
	endfunction

	task automatic busWrite(input int block, input int offset, input logic [31:0] data);
		@(posedge sysClk);
		usiWEd  <= 1'b1;
		usiREd  <= 1'b0;
		usiAdrs <= makeAdrs(block, offset);
		usiWd   <= data;
	endtask

	// Announces the read to the checker and then issues it
	task automatic busRead(input string name, input int block, input int offset,
		input bit respond, input logic [31:0] exp);
		uChecker.expectRead(name, respond, exp);
		@(posedge sysClk);
		usiWEd  <= 1'b0;
		usiREd  <= 1'b1;
		usiAdrs <= makeAdrs(block, offset);
	endtask

	task automatic driveIdle();
		@(posedge sysClk);
		usiWEd <= 1'b0;
		usiREd <= 1'b0;
	endtask

	task automatic waitReads(input string what);
		int n;
		n = 0;
		while (uChecker.outstanding() > 0 && n < 40)
		begin
			@(posedge sysClk);
			n++;
		end
		if (uChecker.outstanding() > 0)
			uChecker.failTest($sformatf("timeout waiting for the %s reads to finish", what));
	endtask

	//------------------------------
	// Test sequence
	//------------------------------
	initial
	begin
		rstN      = 1'b0;
		usiWd     = '0;
		usiAdrs   = '0;
		usiWEd    = 1'b0;
		usiREd    = 1'b0;
		lfsrState = 8'd84;
		syncVal   = '{6, 2, 2, 3, 3, 1, 1, 2};
		repeat (5) @(posedge sysClk);
		rstN <= 1'b1;
		uChecker.checkResetState("reset state");

		// GPIO write shows on the pins two cycles later
		wd     = lfsrTake(lfsrState, 32);
		ledExp = refCsr(procPkg::lpGpioAdrsMap, procPkg::lpGpioLedCsr, wd);
		busWrite(procPkg::lpGpioAdrsMap, procPkg::lpGpioLedCsr, wd);
		driveIdle();
		@(posedge sysClk);
		uChecker.checkLeds("gpio leds", ledExp[4:0]);
		busRead("gpio readback", procPkg::lpGpioAdrsMap, procPkg::lpGpioLedCsr, 1'b1, ledExp);
		driveIdle();
		waitReads("gpio");

		// Video timing CSRs read back to back
		for (int i = 1; i <= 8; i++)
		begin
			vtbWd[i] = lfsrTake(lfsrState, 32);
			busWrite(procPkg::lpVtbAdrsMap, i, vtbWd[i]);
		end
		for (int i = 1; i <= 8; i++)
			busRead($sformatf("vtb csr %0d readback", i), procPkg::lpVtbAdrsMap, i, 1'b1,
				refCsr(procPkg::lpVtbAdrsMap, i, vtbWd[i]));
		driveIdle();
		waitReads("vtb csr");

		busWrite(procPkg::lpVtbAdrsMap, procPkg::lpVtbCtrlCsr, 32'd2);
		driveIdle();
		@(posedge sysClk);
		uChecker.checkBackLight("backlight on", 1'b1);
		busRead("vtb ctrl readback", procPkg::lpVtbAdrsMap, procPkg::lpVtbCtrlCsr, 1'b1,
			refCsr(procPkg::lpVtbAdrsMap, procPkg::lpVtbCtrlCsr, 32'd2));
		driveIdle();
		waitReads("vtb ctrl");

		// Nothing answers these
		busRead("read block 7", 7, 0, 1'b0, '0);
		busRead("read gpio offset 3", procPkg::lpGpioAdrsMap, 3, 1'b0, '0);
		driveIdle();
		waitReads("unmapped");
		busWrite(7, 0, ~wd);
		driveIdle();
		@(posedge sysClk);
		uChecker.checkLeds("write block 7", ledExp[4:0]);

		// Small frame so a full one fits in a few hundred cycles
		for (int i = 1; i <= 8; i++)
			busWrite(procPkg::lpVtbAdrsMap, i, syncVal[i]);
		busWrite(procPkg::lpVtbAdrsMap, procPkg::lpVtbCtrlCsr, 32'd3);
		driveIdle();
		refTiming(syncVal[1], syncVal[2], syncVal[3], syncVal[4], syncVal[5],
			hSyncW, linePeriod, deRun, deLines);
		uChecker.measureSync(hSyncW, linePeriod, deRun, deLines);

		uChecker.printCounts();
		if (uChecker.failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+include
hw/procPkg.sv
hw/usiBus.sv
hw/gpioBlock.sv
hw/videoSyncGen.sv
hw/videoTxBlock.sv
hw/processor.sv
tb/tbClock.sv
tb/tbChecker.sv
tb/tbTop.sv

//--- Makefile
# Verilator flow for the USI bus, GPIO and video transmit design

VERILATOR ?= verilator
TOP       ?= tbTop
RTL_TOP   ?= processor
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_TEXT ?= Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
